// ==== Makefile ====
TOP := mips_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module mips_cpu_harvard \
		source/mips_pkg.sv source/instr_decoder.sv source/register_file.sv \
		source/execute_unit.sv source/pc_unit.sv source/mips_cpu_harvard.sv
	verilator --lint-only --timing --assert --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f all.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== all.f ====
source/mips_pkg.sv
source/instr_decoder.sv
source/register_file.sv
source/execute_unit.sv
source/pc_unit.sv
source/mips_cpu_harvard.sv
dv/clock_gen.sv
dv/mips_tb.sv

// ==== dv/clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
    output logic clk
);

    // 100 ns period, first rising edge at 50 ns
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== dv/mips_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_tb;

    localparam int ROM_WORDS = 256;
    localparam int MAX_CYCLES = 2000;
    localparam logic [31:0] RAM_BASE = 32'h0000_1000;
    localparam logic [15:0] LOAD_OFF = 16'h0200;
    localparam logic [15:0] SKIP_OFF = 16'h03FC;
    localparam logic [31:0] SKIP_ADDR = RAM_BASE + {16'h0000, SKIP_OFF};
    localparam logic [31:0] LOAD_ADDR = RAM_BASE + {16'h0000, LOAD_OFF};
    localparam logic [31:0] LOAD_WORD = 32'h1357_9BDF;
    localparam logic [31:0] A = 32'h0000_0005;
    localparam logic [31:0] B = 32'hFFFF_FFFD;

    logic        clk;
    logic        reset;
    logic        clk_enable;
    logic [31:0] instr_readdata;
    logic [31:0] data_readdata;
    logic        active;
    logic        data_write;
    logic        data_read;
    logic [31:0] instr_address;
    logic [31:0] data_address;
    logic [31:0] data_writedata;
    logic [31:0] register_v0;

    logic [31:0] rom [0:ROM_WORDS-1];
    logic [31:0] ram [0:255];
    logic [31:0] exp_addr [0:255];
    logic [31:0] exp_data [0:255];
    logic [31:0] rom_index;
    logic [31:0] exp_v0;
    logic [31:0] load_pc;
    logic [31:0] prev_addr;
    logic [31:0] prev_v0;
    int          rom_count;
    int          exp_count;
    int          store_count;
    int          cycles;
    integer      seed;

    clock_gen u_clock (
        .clk (clk)
    );

    mips_cpu_harvard dut (
        .clk            (clk),
        .reset          (reset),
        .clk_enable     (clk_enable),
        .instr_readdata (instr_readdata),
        .data_readdata  (data_readdata),
        .active         (active),
        .data_write     (data_write),
        .data_read      (data_read),
        .instr_address  (instr_address),
        .data_address   (data_address),
        .data_writedata (data_writedata),
        .register_v0    (register_v0)
    );

    // Addresses outside the ROM fetch a no-op
    assign rom_index = (instr_address - mips_pkg::RESET_VECTOR) >> 2;
    assign instr_readdata = (rom_index < ROM_WORDS) ? rom[rom_index[7:0]] : 32'h0000_0000;
    assign data_readdata = ram[data_address[9:2]];

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 256; i++) begin
                // Fill word tracks its own byte address
                ram[i] <= ~(RAM_BASE + 32'(4 * i));
            end
            ram[LOAD_OFF[9:2]] <= LOAD_WORD;
            store_count <= 0;
        end else if (data_write) begin
            ram[data_address[9:2]] <= data_writedata;
            store_count <= store_count + 1;
        end
    end

    always @(posedge clk) begin
        prev_addr <= instr_address;
        prev_v0 <= register_v0;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    function automatic logic [31:0] r_type(input logic [5:0] funct, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd,
                                           input logic [4:0] shamt);
        return {6'b000000, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_type(input logic [5:0] op, input logic [31:0] addr);
        return {op, addr[27:2]};
    endfunction

    function automatic logic [31:0] addr_of(input int index);
        return mips_pkg::RESET_VECTOR + 32'(4 * index);
    endfunction

    task automatic place(input logic [31:0] word);
        rom[rom_count] = word;
        rom_count++;
    endtask

    // SW to the next free slot, recorded in the expected-store table
    task automatic store_reg(input logic [4:0] rt, input logic [31:0] value);
        place(i_type(mips_pkg::OP_SW, 5'd16, rt, 16'(4 * exp_count)));
        exp_addr[exp_count] = RAM_BASE + 32'(4 * exp_count);
        exp_data[exp_count] = value;
        exp_count++;
    endtask

    task automatic alu_case(input logic [31:0] word, input logic [31:0] value);
        place(word);
        store_reg(5'd10, value);
    endtask

    // Offset 2 puts the target three words past the branch
    task automatic branch_case(input logic [31:0] word, input bit taken,
                               input logic [31:0] mark);
        place(word);
        place(i_type(mips_pkg::OP_ADDIU, 5'd0, 5'd13, mark[15:0]));
        if (taken) begin
            place(i_type(mips_pkg::OP_SW, 5'd16, 5'd15, SKIP_OFF));
        end else begin
            store_reg(5'd13, mark);
        end
        store_reg(5'd13, mark);
    endtask

    task automatic jump_case(input logic [5:0] op, input logic [31:0] mark);
        logic [31:0] call_addr;
        call_addr = addr_of(rom_count);
        place(j_type(op, addr_of(rom_count + 3)));
        place(i_type(mips_pkg::OP_ADDIU, 5'd0, 5'd13, mark[15:0]));
        place(i_type(mips_pkg::OP_SW, 5'd16, 5'd15, SKIP_OFF));
        store_reg(5'd13, mark);
        if (op == mips_pkg::OP_JAL) begin
            store_reg(5'd31, call_addr + 32'd8);
        end
    endtask

    task automatic build_program();
        logic [31:0] target;
        logic [31:0] call_addr;
        // Store at the reset vector, fetched all through reset
        place(i_type(mips_pkg::OP_SW, 5'd0, 5'd0, RAM_BASE[15:0]));
        exp_addr[exp_count] = RAM_BASE;
        exp_data[exp_count] = 32'h0000_0000;
        exp_count++;

        // r16 store base, r8 and r9 operands, r15 skip marker
        place(i_type(mips_pkg::OP_ORI, 5'd0, 5'd16, RAM_BASE[15:0]));
        place(i_type(mips_pkg::OP_ADDIU, 5'd0, 5'd8, A[15:0]));
        place(i_type(mips_pkg::OP_ADDIU, 5'd0, 5'd9, B[15:0]));
        place(i_type(mips_pkg::OP_ADDIU, 5'd0, 5'd15, 16'h0BAD));

        alu_case(r_type(mips_pkg::FN_ADDU, 5'd8, 5'd9, 5'd10, 5'd0), A + B);
        alu_case(r_type(mips_pkg::FN_SUBU, 5'd8, 5'd9, 5'd10, 5'd0), A - B);
        alu_case(r_type(mips_pkg::FN_AND, 5'd8, 5'd9, 5'd10, 5'd0), A & B);
        alu_case(r_type(mips_pkg::FN_OR, 5'd8, 5'd9, 5'd10, 5'd0), A | B);
        alu_case(r_type(mips_pkg::FN_XOR, 5'd8, 5'd9, 5'd10, 5'd0), A ^ B);
        alu_case(r_type(mips_pkg::FN_SLT, 5'd9, 5'd8, 5'd10, 5'd0),
                 ($signed(B) < $signed(A)) ? 32'd1 : 32'd0);
        alu_case(r_type(mips_pkg::FN_SLT, 5'd8, 5'd9, 5'd10, 5'd0),
                 ($signed(A) < $signed(B)) ? 32'd1 : 32'd0);
        alu_case(r_type(mips_pkg::FN_SLTU, 5'd9, 5'd8, 5'd10, 5'd0),
                 (B < A) ? 32'd1 : 32'd0);
        alu_case(r_type(mips_pkg::FN_SLL, 5'd0, 5'd9, 5'd10, 5'd4), B << 4);
        alu_case(r_type(mips_pkg::FN_SRL, 5'd0, 5'd9, 5'd10, 5'd4), B >> 4);
        alu_case(r_type(mips_pkg::FN_SRA, 5'd0, 5'd9, 5'd10, 5'd1), $signed(B) >>> 1);
        alu_case(r_type(mips_pkg::FN_SLLV, 5'd8, 5'd9, 5'd10, 5'd0), B << A[4:0]);
        alu_case(r_type(mips_pkg::FN_SRLV, 5'd8, 5'd9, 5'd10, 5'd0), B >> A[4:0]);
        alu_case(r_type(mips_pkg::FN_SRAV, 5'd8, 5'd9, 5'd10, 5'd0), $signed(B) >>> A[4:0]);
        alu_case(i_type(mips_pkg::OP_ADDIU, 5'd9, 5'd10, 16'h7FF0), B + 32'h0000_7FF0);
        alu_case(i_type(mips_pkg::OP_ADDIU, 5'd8, 5'd10, 16'hFF00), A + 32'hFFFF_FF00);
        alu_case(i_type(mips_pkg::OP_ANDI, 5'd9, 5'd10, 16'hF0F0), B & 32'h0000_F0F0);
        alu_case(i_type(mips_pkg::OP_ORI, 5'd8, 5'd10, 16'h8000), A | 32'h0000_8000);
        alu_case(i_type(mips_pkg::OP_XORI, 5'd9, 5'd10, 16'h00FF), B ^ 32'h0000_00FF);
        alu_case(i_type(mips_pkg::OP_SLTI, 5'd9, 5'd10, 16'hFFFE),
                 ($signed(B) < $signed(32'hFFFF_FFFE)) ? 32'd1 : 32'd0);
        alu_case(i_type(mips_pkg::OP_SLTIU, 5'd8, 5'd10, 16'hFFFF),
                 (A < 32'hFFFF_FFFF) ? 32'd1 : 32'd0);
        alu_case(i_type(mips_pkg::OP_LUI, 5'd0, 5'd10, 16'h1234), 32'h1234_0000);

        load_pc = addr_of(rom_count);
        place(i_type(mips_pkg::OP_LW, 5'd16, 5'd11, LOAD_OFF));
        place(i_type(mips_pkg::OP_ADDIU, 5'd11, 5'd12, 16'h0123));
        store_reg(5'd12, LOAD_WORD + 32'h0000_0123);

        branch_case(i_type(mips_pkg::OP_BEQ, 5'd8, 5'd8, 16'd2), 1'b1, 32'h0B01);
        branch_case(i_type(mips_pkg::OP_BEQ, 5'd8, 5'd9, 16'd2), 1'b0, 32'h0B02);
        branch_case(i_type(mips_pkg::OP_BNE, 5'd8, 5'd9, 16'd2), 1'b1, 32'h0B03);
        branch_case(i_type(mips_pkg::OP_BNE, 5'd8, 5'd8, 16'd2), 1'b0, 32'h0B04);
        branch_case(i_type(mips_pkg::OP_BGTZ, 5'd8, 5'd0, 16'd2), 1'b1, 32'h0B05);
        branch_case(i_type(mips_pkg::OP_BGTZ, 5'd9, 5'd0, 16'd2), 1'b0, 32'h0B06);
        branch_case(i_type(mips_pkg::OP_BGTZ, 5'd0, 5'd0, 16'd2), 1'b0, 32'h0B07);
        branch_case(i_type(mips_pkg::OP_BLEZ, 5'd9, 5'd0, 16'd2), 1'b1, 32'h0B08);
        branch_case(i_type(mips_pkg::OP_BLEZ, 5'd0, 5'd0, 16'd2), 1'b1, 32'h0B09);
        branch_case(i_type(mips_pkg::OP_BLEZ, 5'd8, 5'd0, 16'd2), 1'b0, 32'h0B0A);
        branch_case(i_type(mips_pkg::OP_REGIMM, 5'd9, mips_pkg::RI_BLTZ, 16'd2), 1'b1, 32'h0B0B);
        branch_case(i_type(mips_pkg::OP_REGIMM, 5'd8, mips_pkg::RI_BLTZ, 16'd2), 1'b0, 32'h0B0C);
        branch_case(i_type(mips_pkg::OP_REGIMM, 5'd8, mips_pkg::RI_BGEZ, 16'd2), 1'b1, 32'h0B0D);
        branch_case(i_type(mips_pkg::OP_REGIMM, 5'd0, mips_pkg::RI_BGEZ, 16'd2), 1'b1, 32'h0B0E);
        branch_case(i_type(mips_pkg::OP_REGIMM, 5'd9, mips_pkg::RI_BGEZ, 16'd2), 1'b0, 32'h0B0F);

        jump_case(mips_pkg::OP_J, 32'h0C01);
        jump_case(mips_pkg::OP_JAL, 32'h0C02);

        // JALR target lands five words after the LUI
        target = addr_of(rom_count + 5);
        place(i_type(mips_pkg::OP_LUI, 5'd0, 5'd20, target[31:16]));
        place(i_type(mips_pkg::OP_ORI, 5'd20, 5'd20, target[15:0]));
        call_addr = addr_of(rom_count);
        place(r_type(mips_pkg::FN_JALR, 5'd20, 5'd0, 5'd21, 5'd0));
        place(i_type(mips_pkg::OP_ADDIU, 5'd0, 5'd13, 16'h0C03));
        place(i_type(mips_pkg::OP_SW, 5'd16, 5'd15, SKIP_OFF));
        store_reg(5'd13, 32'h0000_0C03);
        store_reg(5'd21, call_addr + 32'd8);

        // v0 sum, then JR to zero with the last add in its delay slot
        place(r_type(mips_pkg::FN_ADDU, 5'd8, 5'd12, 5'd2, 5'd0));
        place(r_type(mips_pkg::FN_JR, 5'd0, 5'd0, 5'd0, 5'd0));
        place(i_type(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0007));
        place(i_type(mips_pkg::OP_SW, 5'd16, 5'd15, SKIP_OFF));
        exp_v0 = A + LOAD_WORD + 32'h0000_0123 + 32'h0000_0007;
    endtask

    a_reset_quiet: assert property (@(posedge clk) reset |-> !data_write)
        else fail_now("data_write went high while reset was asserted");

    a_reset_vector: assert property (@(posedge clk)
        $fell(reset) |-> active && instr_address == mips_pkg::RESET_VECTOR)
        else fail_now($sformatf("error instr_address got %h expected %h, active %h",
            $sampled(instr_address), mips_pkg::RESET_VECTOR, $sampled(active)));

    a_store_count: assert property (@(posedge clk) disable iff (reset)
        data_write |-> store_count < exp_count)
        else fail_now("more stores reached memory than the program should make");

    a_store_addr: assert property (@(posedge clk) disable iff (reset)
        data_write |-> data_address == exp_addr[store_count])
        else fail_now($sformatf("error data_address got %h expected %h",
            $sampled(data_address), exp_addr[$sampled(store_count)]));

    a_store_data: assert property (@(posedge clk) disable iff (reset)
        data_write |-> data_writedata == exp_data[store_count])
        else fail_now($sformatf("error data_writedata got %h expected %h",
            $sampled(data_writedata), exp_data[$sampled(store_count)]));

    a_no_skipped: assert property (@(posedge clk) disable iff (reset)
        data_write |-> data_address != SKIP_ADDR)
        else fail_now("an instruction that should have been skipped stored to memory");

    a_ram_window: assert property (@(posedge clk) disable iff (reset)
        (data_write || data_read) |-> data_address[31:10] == RAM_BASE[31:10])
        else fail_now($sformatf("error data_address got %h outside the data RAM",
            $sampled(data_address)));

    // Only the single LW in the program may raise data_read
    a_load_strobe: assert property (@(posedge clk) disable iff (reset)
        data_read == (instr_address == load_pc))
        else fail_now($sformatf("error data_read got %h expected %h",
            $sampled(data_read), $sampled(instr_address) == load_pc));

    a_load_addr: assert property (@(posedge clk) disable iff (reset)
        data_read |-> data_address == LOAD_ADDR)
        else fail_now($sformatf("error data_address got %h expected %h on the load",
            $sampled(data_address), LOAD_ADDR));

    a_stall_no_write: assert property (@(posedge clk) disable iff (reset)
        !clk_enable |-> !data_write)
        else fail_now("data_write was high while clk_enable was low");

    a_stall_pc: assert property (@(posedge clk) disable iff (reset)
        !clk_enable |=> instr_address == prev_addr)
        else fail_now($sformatf("error instr_address got %h expected %h after a stall",
            $sampled(instr_address), $sampled(prev_addr)));

    a_stall_v0: assert property (@(posedge clk) disable iff (reset)
        !clk_enable |=> register_v0 == prev_v0)
        else fail_now($sformatf("error register_v0 got %h expected %h after a stall",
            $sampled(register_v0), $sampled(prev_v0)));

    a_halted: assert property (@(posedge clk) disable iff (reset)
        !active |-> instr_address == 32'h0 && !data_write && register_v0 == exp_v0)
        else fail_now($sformatf("error register_v0 got %h expected %h, instr_address %h",
            $sampled(register_v0), exp_v0, $sampled(instr_address)));

    initial begin
        seed = 32'h7dc9_7871;
        reset = 1'b1;
        clk_enable = 1'b1;
        rom_count = 0;
        exp_count = 0;
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = 32'h0000_0000;
        end
        build_program();

        repeat (10) @(negedge clk);
        reset = 1'b0;

        cycles = 0;
        while (active && cycles < MAX_CYCLES) begin
            @(negedge clk);
            clk_enable = ($random(seed) & 3) != 0;
            cycles++;
        end

        if (active) begin
            fail_now("timeout while waiting for the core to halt");
        end else begin
            // Keep the parked core under watch for a few edges
            repeat (8) @(negedge clk);
            if (store_count != exp_count) begin
                fail_now($sformatf("only %0d of %0d expected stores were seen",
                    store_count, exp_count));
            end else begin
                $display("TEST PASS");
                $finish;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/execute_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module execute_unit (
    input  mips_pkg::decoded_t dec,
    input  logic [31:0]        rs_value,
    input  logic [31:0]        rt_value,
    input  logic [31:0]        pc,
    input  logic [31:0]        data_readdata,
    input  logic               run,
    output mips_pkg::wb_t      wb,
    output mips_pkg::branch_t  br,
    output logic [31:0]        data_address,
    output logic [31:0]        data_writedata,
    output logic               data_write,
    output logic               data_read
);

    logic [31:0] op_b;
    logic [31:0] alu_result;
    logic [31:0] seq_pc;
    logic [31:0] link_addr;
    logic [4:0]  shift_amt;
    logic        cond;

    assign op_b = dec.use_imm ? dec.imm_ext : rt_value;
    assign shift_amt = dec.shift_var ? rs_value[4:0] : dec.shamt;
    assign seq_pc = pc + 32'd4;
    // Return past the delay slot
    assign link_addr = pc + 32'd8;

    always_comb begin
        case (dec.alu_op)
            mips_pkg::ALU_ADD:  alu_result = rs_value + op_b;
            mips_pkg::ALU_SUB:  alu_result = rs_value - op_b;
            mips_pkg::ALU_AND:  alu_result = rs_value & op_b;
            mips_pkg::ALU_OR:   alu_result = rs_value | op_b;
            mips_pkg::ALU_XOR:  alu_result = rs_value ^ op_b;
            mips_pkg::ALU_SLT:  alu_result = {31'b0, $signed(rs_value) < $signed(op_b)};
            mips_pkg::ALU_SLTU: alu_result = {31'b0, rs_value < op_b};
            mips_pkg::ALU_SLL:  alu_result = rt_value << shift_amt;
            mips_pkg::ALU_SRL:  alu_result = rt_value >> shift_amt;
            mips_pkg::ALU_SRA:  alu_result = $signed(rt_value) >>> shift_amt;
            mips_pkg::ALU_LUI:  alu_result = {dec.imm_ext[15:0], 16'h0000};
            mips_pkg::ALU_PASS_LINK: alu_result = link_addr;
            default:            alu_result = '0;
        endcase
    end

    always_comb begin
        case (dec.branch)
            mips_pkg::BR_EQ:     cond = (rs_value == rt_value);
            mips_pkg::BR_NE:     cond = (rs_value != rt_value);
            mips_pkg::BR_GTZ:    cond = !rs_value[31] && (rs_value != '0);
            mips_pkg::BR_LEZ:    cond = rs_value[31] || (rs_value == '0);
            mips_pkg::BR_LTZ:    cond = rs_value[31];
            mips_pkg::BR_GEZ:    cond = !rs_value[31];
            mips_pkg::BR_ALWAYS: cond = 1'b1;
            default:             cond = 1'b0;
        endcase
    end

    always_comb begin
        br.taken = cond;
        if (dec.jump_reg) begin
            br.target = rs_value;
        end else if (dec.jump_abs) begin
            br.target = {pc[31:28], dec.target26, 2'b00};
        end else begin
            // Offset is relative to the delay slot
            br.target = seq_pc + {dec.imm_ext[29:0], 2'b00};
        end
    end

    assign data_address = rs_value + dec.imm_ext;
    assign data_writedata = rt_value;
    assign data_write = run && dec.is_store;
    assign data_read = dec.is_load;

    assign wb.en = run && dec.reg_write;
    assign wb.addr = dec.dest;
    assign wb.data = dec.is_load ? data_readdata : alu_result;

    // Decoder never flags one word as both load and store
    always_comb begin
        a_rw_exclusive: assert (!(data_write && data_read))
            else $error("data_write and data_read both high");
    end

endmodule

`default_nettype wire

// ==== source/instr_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
    input  mips_pkg::instr_u   instr,
    output mips_pkg::decoded_t dec
);

    logic write_req;

    always_comb begin
        dec = '0;
        write_req = 1'b0;
        dec.alu_op = mips_pkg::ALU_ADD;
        dec.branch = mips_pkg::BR_NONE;
        dec.rs = instr.r.rs;
        dec.rt = instr.r.rt;
        dec.dest = instr.i.rt;
        dec.shamt = instr.r.shamt;
        dec.imm_ext = {{16{instr.i.imm[15]}}, instr.i.imm};
        dec.target26 = instr.j.target;

        case (instr.r.opcode)
            mips_pkg::OP_SPECIAL: begin
                dec.dest = instr.r.rd;
                write_req = 1'b1;
                case (instr.r.funct)
                    mips_pkg::FN_SLL:  dec.alu_op = mips_pkg::ALU_SLL;
                    mips_pkg::FN_SRL:  dec.alu_op = mips_pkg::ALU_SRL;
                    mips_pkg::FN_SRA:  dec.alu_op = mips_pkg::ALU_SRA;
                    mips_pkg::FN_SLLV: begin
                        dec.alu_op = mips_pkg::ALU_SLL;
                        dec.shift_var = 1'b1;
                    end
                    mips_pkg::FN_SRLV: begin
                        dec.alu_op = mips_pkg::ALU_SRL;
                        dec.shift_var = 1'b1;
                    end
                    mips_pkg::FN_SRAV: begin
                        dec.alu_op = mips_pkg::ALU_SRA;
                        dec.shift_var = 1'b1;
                    end
                    mips_pkg::FN_JR: begin
                        dec.branch = mips_pkg::BR_ALWAYS;
                        dec.jump_reg = 1'b1;
                        write_req = 1'b0;
                    end
                    mips_pkg::FN_JALR: begin
                        dec.branch = mips_pkg::BR_ALWAYS;
                        dec.jump_reg = 1'b1;
                        dec.alu_op = mips_pkg::ALU_PASS_LINK;
                    end
                    mips_pkg::FN_ADDU: dec.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: dec.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  dec.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   dec.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  dec.alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT:  dec.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLTU: dec.alu_op = mips_pkg::ALU_SLTU;
                    default: write_req = 1'b0;
                endcase
            end
            mips_pkg::OP_REGIMM: begin
                case (instr.i.rt)
                    mips_pkg::RI_BLTZ: dec.branch = mips_pkg::BR_LTZ;
                    mips_pkg::RI_BGEZ: dec.branch = mips_pkg::BR_GEZ;
                    default:           dec.branch = mips_pkg::BR_NONE;
                endcase
            end
            mips_pkg::OP_J: begin
                dec.branch = mips_pkg::BR_ALWAYS;
                dec.jump_abs = 1'b1;
            end
            mips_pkg::OP_JAL: begin
                dec.branch = mips_pkg::BR_ALWAYS;
                dec.jump_abs = 1'b1;
                dec.alu_op = mips_pkg::ALU_PASS_LINK;
                dec.dest = mips_pkg::RA_INDEX;
                write_req = 1'b1;
            end
            mips_pkg::OP_BEQ:  dec.branch = mips_pkg::BR_EQ;
            mips_pkg::OP_BNE:  dec.branch = mips_pkg::BR_NE;
            mips_pkg::OP_BLEZ: dec.branch = mips_pkg::BR_LEZ;
            mips_pkg::OP_BGTZ: dec.branch = mips_pkg::BR_GTZ;
            mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU,
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI: begin
                dec.use_imm = 1'b1;
                write_req = 1'b1;
                case (instr.r.opcode)
                    mips_pkg::OP_SLTI:  dec.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::OP_SLTIU: dec.alu_op = mips_pkg::ALU_SLTU;
                    mips_pkg::OP_ANDI:  dec.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::OP_ORI:   dec.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::OP_XORI:  dec.alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::OP_LUI:   dec.alu_op = mips_pkg::ALU_LUI;
                    default:            dec.alu_op = mips_pkg::ALU_ADD;
                endcase
                // Logical immediates are zero extended
                if (instr.r.opcode inside {mips_pkg::OP_ANDI, mips_pkg::OP_ORI,
                                           mips_pkg::OP_XORI}) begin
                    dec.imm_ext = {16'h0000, instr.i.imm};
                end
            end
            mips_pkg::OP_LW: begin
                dec.is_load = 1'b1;
                write_req = 1'b1;
            end
            mips_pkg::OP_SW: dec.is_store = 1'b1;
            default: ;
        endcase

        // r0 writes are dropped here
        dec.reg_write = write_req && (dec.dest != '0);
    end

endmodule

`default_nettype wire

// ==== source/mips_cpu_harvard.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_cpu_harvard (
    input  logic        clk,
    input  logic        reset,
    input  logic        clk_enable,
    input  logic [31:0] instr_readdata,
    input  logic [31:0] data_readdata,
    output logic        active,
    output logic        data_write,
    output logic        data_read,
    output logic [31:0] instr_address,
    output logic [31:0] data_address,
    output logic [31:0] data_writedata,
    output logic [31:0] register_v0
);

    mips_pkg::instr_u   instr;
    mips_pkg::decoded_t dec;
    mips_pkg::wb_t      wb;
    mips_pkg::branch_t  br;
    logic [31:0]        rs_value;
    logic [31:0]        rt_value;
    logic [31:0]        pc;
    logic               run;

    assign instr = instr_readdata;
    assign instr_address = pc;

    instr_decoder u_decoder (
        .instr (instr),
        .dec   (dec)
    );

    register_file u_regs (
        .clk      (clk),
        .reset    (reset),
        .rs_addr  (dec.rs),
        .rt_addr  (dec.rt),
        .wb       (wb),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .v0       (register_v0)
    );

    execute_unit u_exec (
        .dec            (dec),
        .rs_value       (rs_value),
        .rt_value       (rt_value),
        .pc             (pc),
        .data_readdata  (data_readdata),
        .run            (run),
        .wb             (wb),
        .br             (br),
        .data_address   (data_address),
        .data_writedata (data_writedata),
        .data_write     (data_write),
        .data_read      (data_read)
    );

    // Sequencing, delay slot and halt
    pc_unit u_pc (
        .clk        (clk),
        .reset      (reset),
        .clk_enable (clk_enable),
        .br         (br),
        .pc         (pc),
        .run        (run),
        .active     (active)
    );

endmodule

`default_nettype wire

// ==== source/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    localparam int WORD_W = 32;
    localparam int REG_ADDR_W = 5;
    localparam logic [WORD_W-1:0] RESET_VECTOR = 32'hBFC0_0000;
    localparam logic [REG_ADDR_W-1:0] V0_INDEX = 5'd2;
    localparam logic [REG_ADDR_W-1:0] RA_INDEX = 5'd31;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_REGIMM  = 6'b000001,
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_LW      = 6'b100011,
        OP_SW      = 6'b101011
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_JR   = 6'b001000,
        FN_JALR = 6'b001001,
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    // Branch selector lives in the rt field
    typedef enum logic [4:0] {
        RI_BLTZ = 5'b00000,
        RI_BGEZ = 5'b00001
    } regimm_e;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [15:0]           imm;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_PASS_LINK
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_GTZ, BR_LEZ, BR_LTZ, BR_GEZ, BR_ALWAYS
    } branch_e;

    typedef struct packed {
        alu_op_e               alu_op;
        branch_e               branch;
        logic                  jump_reg;
        logic                  jump_abs;
        logic                  use_imm;
        logic                  shift_var;
        logic                  is_load;
        logic                  is_store;
        logic                  reg_write;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] dest;
        logic [4:0]            shamt;
        logic [WORD_W-1:0]     imm_ext;
        logic [25:0]           target26;
    } decoded_t;

    typedef struct packed {
        logic                  en;
        logic [REG_ADDR_W-1:0] addr;
        logic [WORD_W-1:0]     data;
    } wb_t;

    typedef struct packed {
        logic              taken;
        logic [WORD_W-1:0] target;
    } branch_t;

endpackage

`default_nettype wire

// ==== source/pc_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module pc_unit (
    input  logic              clk,
    input  logic              reset,
    input  logic              clk_enable,
    input  mips_pkg::branch_t br,
    output logic [31:0]       pc,
    output logic              run,
    output logic              active
);

    logic        halted;
    logic        pend_valid;
    logic [31:0] pend_target;

    assign run = !reset && clk_enable && !halted && (pc != '0);
    assign active = !halted;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= mips_pkg::RESET_VECTOR;
            pend_valid <= 1'b0;
            halted <= 1'b0;
        end else if (!halted && pc == '0) begin
            halted <= 1'b1;
        end else if (run) begin
            if (pend_valid) begin
                pc <= pend_target;
            end else begin
                pc <= pc + 32'd4;
            end
            // A branch sitting in a delay slot is not supported
            pend_valid <= br.taken;
        end
    end

    always_ff @(posedge clk) begin
        if (run && br.taken) begin
            pend_target <= br.target;
        end
    end

    a_no_run_when_idle: assert property (
        @(posedge clk) !(run && !active)
    ) else $error("run high while core inactive");

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module register_file (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [4:0]            rs_addr,
    input  logic [4:0]            rt_addr,
    input  mips_pkg::wb_t         wb,
    output logic [31:0]           rs_value,
    output logic [31:0]           rt_value,
    output logic [31:0]           v0
);

    logic [mips_pkg::WORD_W-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.addr != '0) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // Entry zero is never written, so it reads back as zero
    assign rs_value = regs[rs_addr];
    assign rt_value = regs[rt_addr];
    assign v0 = regs[mips_pkg::V0_INDEX];

    // Decoder must already have suppressed r0 destinations
    a_no_r0_write: assert property (
        @(posedge clk) disable iff (reset) wb.en |-> (wb.addr != '0)
    ) else $error("write enabled to register zero");

endmodule

`default_nettype wire
